//--- flist.f
logic/cu_cache_pkg.sv
logic/cu_sync_fifo.sv
logic/cu_request_ingress.sv
logic/cu_command_sequencer.sv
logic/cu_response_egress.sv
logic/cu_cache_top.sv
sim/cu_cache_asserts.sv
sim/cu_cache_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module cu_cache_tb -o cu_cache_sim

output=$(./obj_dir/cu_cache_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "Finished with no errors"; then
  exit 0
fi
exit 1

//--- sim/cu_cache_tb.sv
// testbench for the cache front-end: random traffic, memory model, reference model and checks
`timescale 1ns/1ps

module cu_cache_tb;

  logic                              ap_clk;
  logic                              areset_control;
  logic                              desc_valid_i;
  logic [cu_cache_pkg::ADDR_W-1:0]   desc_base_i;
  logic                              req_valid_i;
  logic                              req_ready_o;
  cu_cache_pkg::cmd_e                req_cmd_i;
  logic [cu_cache_pkg::ADDR_W-1:0]   req_addr_i;
  logic [cu_cache_pkg::DATA_W-1:0]   req_wdata_i;
  logic [cu_cache_pkg::TAG_W-1:0]    req_tag_i;
  logic                              mem_valid_o;
  logic [cu_cache_pkg::ADDR_W-1:0]   mem_addr_o;
  logic [cu_cache_pkg::DATA_W-1:0]   mem_wdata_o;
  logic [cu_cache_pkg::STRB_W-1:0]   mem_wstrb_o;
  logic                              mem_ready_i;
  logic [cu_cache_pkg::DATA_W-1:0]   mem_rdata_i;
  logic                              mem_rvalid_i;
  logic                              resp_valid_o;
  logic                              resp_ready_i;
  cu_cache_pkg::cmd_e                resp_cmd_o;
  logic [cu_cache_pkg::TAG_W-1:0]    resp_tag_o;
  logic [cu_cache_pkg::DATA_W-1:0]   resp_data_o;
  logic                              done_o;

  // traffic control
  logic        hold_resp;
  logic        always_ready;
  logic [31:0] desc_base;
  logic [7:0]  next_tag;

  // expected issues {cmd, addr, wdata} and responses {cmd, tag, data}
  logic [64:0] exp_issue_q [$];
  logic [40:0] exp_resp_q [$];
  // reference copy and memory model contents
  logic [31:0] model_mem [logic [31:0]];
  logic [31:0] mem_store [logic [31:0]];

  // one outstanding read in the memory model
  logic        rd_pending;
  int          rd_wait;
  logic [31:0] rd_addr;

  cu_cache_top u_dut (.*);

  bind cu_cache_top cu_cache_asserts u_asserts (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .mem_valid_i    (mem_valid_o),
    .mem_ready_i    (mem_ready_i),
    .resp_valid_i   (resp_valid_o),
    .resp_ready_i   (resp_ready_i),
    .resp_cmd_i     (resp_cmd_o),
    .resp_tag_i     (resp_tag_o),
    .resp_data_i    (resp_data_o)
  );

  // ------------------------------
  // helpers
  // ------------------------------
  // never-written words, unique per address
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return addr ^ 32'h5a5a_c3c3;
  endfunction

  task automatic abort_run(input string what);
    $display("%s (at %0t)", what, $time);
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("[ERROR] %0t %s: got %08h, expected %08h", $time, what, actual, expected);
      $display("Finished with errors");
      $fatal(1, "value mismatch");
    end
  endtask

  // called on a falling edge with req_ready_o high, so the beat transfers next edge
  task automatic drive_request(input logic is_wr, input logic [31:0] addr,
                               input logic [31:0] wdata);
    logic [31:0] maddr;
    logic [31:0] exp_data;
    maddr = addr + desc_base;
    req_valid_i = 1'b1;
    req_cmd_i   = is_wr ? cu_cache_pkg::CMD_WRITE : cu_cache_pkg::CMD_READ;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    req_tag_i   = next_tag;
    // requests complete in order, so the model updates at acceptance
    if (is_wr) begin
      model_mem[maddr] = wdata;
      exp_data = wdata;
    end else begin
      exp_data = model_mem.exists(maddr) ? model_mem[maddr] : fill_word(maddr);
    end
    exp_issue_q.push_back({is_wr, maddr, wdata});
    exp_resp_q.push_back({is_wr, next_tag, exp_data});
    next_tag = next_tag + 8'd1;
  endtask

  task automatic send_request(input logic is_wr, input logic [31:0] addr,
                              input logic [31:0] wdata);
    int waited;
    waited = 0;
    @(negedge ap_clk);
    while (!req_ready_o) begin
      req_valid_i = 1'b0;
      waited++;
      if (waited > 300) abort_run("timeout waiting for req_ready_o");
      @(negedge ap_clk);
    end
    drive_request(is_wr, addr, wdata);
  endtask

  task automatic release_request();
    @(negedge ap_clk);
    req_valid_i = 1'b0;
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_resp_q.size() != 0) begin
      @(negedge ap_clk);
      waited++;
      if (waited > 3000) abort_run("timeout waiting for all responses to drain");
    end
  endtask

  // ------------------------------
  // clock
  // ------------------------------
  initial begin : clock_gen
    ap_clk = 1'b0;
    forever #5 ap_clk = ~ap_clk;
  end

  // ------------------------------
  // memory model
  // ------------------------------
  initial begin : memory_model
    logic [64:0] issue;
    mem_ready_i  = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    rd_pending   = 1'b0;
    rd_wait      = 0;
    rd_addr      = '0;
    forever begin
      @(negedge ap_clk);
      mem_rvalid_i = 1'b0;
      if (rd_pending) begin
        rd_wait--;
        if (rd_wait == 0) begin
          mem_rvalid_i = 1'b1;
          mem_rdata_i  = mem_store.exists(rd_addr) ? mem_store[rd_addr] : fill_word(rd_addr);
          rd_pending   = 1'b0;
        end
      end
      if (mem_valid_o) begin
        if (exp_issue_q.size() == 0) abort_run("memory request issued with nothing pending");
        issue = exp_issue_q.pop_front();
        check_value(mem_addr_o, issue[63:32], "memory address");
        check_value(32'(mem_wstrb_o), issue[64] ? 32'hf : 32'h0, "write strobe");
        if (issue[64]) begin
          check_value(mem_wdata_o, issue[31:0], "write data");
          mem_store[mem_addr_o] = mem_wdata_o;
        end else begin
          // read data 1 to 6 cycles later
          rd_pending = 1'b1;
          rd_addr    = mem_addr_o;
          rd_wait    = 1 + ($urandom % 6);
        end
      end
      mem_ready_i = always_ready || (($urandom % 4) != 0);
    end
  end

  // ------------------------------
  // response side and checker
  // ------------------------------
  initial begin : response_side
    logic [40:0] entry;
    resp_ready_i = 1'b0;
    forever begin
      @(negedge ap_clk);
      resp_ready_i = !hold_resp && (($urandom % 4) != 0);
      // handshake completes on the coming rising edge
      if (resp_valid_o && resp_ready_i) begin
        if (exp_resp_q.size() == 0) abort_run("response returned with no request outstanding");
        entry = exp_resp_q.pop_front();
        check_value(32'(resp_cmd_o), 32'(entry[40]), "response command");
        check_value(32'(resp_tag_o), 32'(entry[39:32]), "response tag");
        check_value(resp_data_o, entry[31:0], "response data");
      end
    end
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin : stimulus
    int   i;
    int   waited;
    logic dropped;
    void'($urandom(32'h489));
    areset_control = 1'b1;
    desc_valid_i   = 1'b0;
    desc_base_i    = '0;
    req_valid_i    = 1'b0;
    req_cmd_i      = cu_cache_pkg::CMD_READ;
    req_addr_i     = '0;
    req_wdata_i    = '0;
    req_tag_i      = '0;
    hold_resp      = 1'b0;
    always_ready   = 1'b0;
    desc_base      = 32'h0001_0000;
    next_tag       = 8'd0;
    repeat (10) @(negedge ap_clk);
    areset_control = 1'b0;

    // requests park in the FIFO until the descriptor shows up
    for (i = 0; i < 4; i++) begin
      send_request(($urandom % 2) == 1, ($urandom % 8) * 4, $urandom);
    end
    release_request();
    repeat (50) begin
      @(negedge ap_clk);
      check_value(32'(mem_valid_o), 32'h0, "mem_valid_o before descriptor");
    end
    @(negedge ap_clk);
    desc_valid_i = 1'b1;
    desc_base_i  = desc_base;
    @(negedge ap_clk);
    desc_valid_i = 1'b0;
    wait_drained();

    // random mix over eight words, with gaps
    for (i = 0; i < 80; i++) begin
      send_request(($urandom % 2) == 1, ($urandom % 8) * 4, $urandom);
      if (($urandom % 4) == 0) release_request();
    end
    release_request();
    wait_drained();

    // engine stalls, keep pushing until ingress pushes back
    @(posedge ap_clk);
    hold_resp = 1'b1;
    dropped = 1'b0;
    waited = 0;
    while (!dropped) begin
      @(negedge ap_clk);
      waited++;
      if (waited > 300) abort_run("req_ready_o never dropped while responses were held");
      if (req_ready_o) begin
        drive_request(($urandom % 2) == 1, ($urandom % 8) * 4, $urandom);
      end else begin
        req_valid_i = 1'b0;
        dropped = 1'b1;
      end
    end
    repeat (30) @(negedge ap_clk);
    @(posedge ap_clk);
    hold_resp = 1'b0;
    wait_drained();

    // done stays low while a response sits in the queue
    @(posedge ap_clk);
    always_ready = 1'b1;
    hold_resp = 1'b1;
    send_request(1'b1, 32'h4, $urandom);
    send_request(1'b0, 32'h4, 32'h0);
    release_request();
    waited = 0;
    while (!resp_valid_o) begin
      @(negedge ap_clk);
      waited++;
      if (waited > 200) abort_run("timeout waiting for resp_valid_o");
    end
    repeat (3) @(negedge ap_clk);
    repeat (20) begin
      @(negedge ap_clk);
      check_value(32'(done_o), 32'h0, "done_o with responses pending");
    end
    @(posedge ap_clk);
    hold_resp = 1'b0;
    wait_drained();
    waited = 0;
    while (!done_o) begin
      @(negedge ap_clk);
      waited++;
      if (waited > 20) abort_run("timeout waiting for done_o after drain");
    end

    if (!u_dut.u_asserts.any_failed) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- sim/cu_cache_asserts.sv
// protocol assertions on the memory and response ports, bound into the cache top level
`timescale 1ns/1ps

module cu_cache_asserts (
  input logic                            ap_clk,
  input logic                            areset_control,
  input logic                            mem_valid_i,
  input logic                            mem_ready_i,
  input logic                            resp_valid_i,
  input logic                            resp_ready_i,
  input cu_cache_pkg::cmd_e              resp_cmd_i,
  input logic [cu_cache_pkg::TAG_W-1:0]  resp_tag_i,
  input logic [cu_cache_pkg::DATA_W-1:0] resp_data_i
);

  // sticky per-property failure flags
  logic pulse_failed = 1'b0;
  logic ready_failed = 1'b0;
  logic stable_failed = 1'b0;
  logic any_failed;

  assign any_failed = pulse_failed | ready_failed | stable_failed;

  // ------------------------------
  // memory port
  // ------------------------------
  // issue is a one-cycle pulse
  valid_single_cycle: assert property (@(posedge ap_clk) disable iff (areset_control)
    mem_valid_i |=> !mem_valid_i)
  else begin
    pulse_failed = 1'b1;
    $error("mem_valid_o stayed high for more than one cycle");
  end

  // ready seen in the cycle before the issue
  valid_needs_ready: assert property (@(posedge ap_clk) disable iff (areset_control)
    mem_valid_i |-> $past(mem_ready_i))
  else begin
    ready_failed = 1'b1;
    $error("mem_valid_o raised without mem_ready_i the cycle before");
  end

  // ------------------------------
  // response port
  // ------------------------------
  // head holds while the engine stalls
  resp_held_stable: assert property (@(posedge ap_clk) disable iff (areset_control)
    (resp_valid_i && !resp_ready_i) |=> (resp_valid_i && $stable(resp_cmd_i)
      && $stable(resp_tag_i) && $stable(resp_data_i)))
  else begin
    stable_failed = 1'b1;
    $error("response changed while resp_ready_i was low");
  end

endmodule

//--- logic/cu_cache_top.sv
// cache front-end top: ingress, command sequencer and egress joined by wires
`timescale 1ns/1ps

module cu_cache_top (
  input  logic                              ap_clk,
  input  logic                              areset_control,
  // kernel descriptor
  input  logic                              desc_valid_i,
  input  logic [cu_cache_pkg::ADDR_W-1:0]   desc_base_i,
  // engine requests
  input  logic                              req_valid_i,
  output logic                              req_ready_o,
  input  cu_cache_pkg::cmd_e                req_cmd_i,
  input  logic [cu_cache_pkg::ADDR_W-1:0]   req_addr_i,
  input  logic [cu_cache_pkg::DATA_W-1:0]   req_wdata_i,
  input  logic [cu_cache_pkg::TAG_W-1:0]    req_tag_i,
  // memory port
  output logic                              mem_valid_o,
  output logic [cu_cache_pkg::ADDR_W-1:0]   mem_addr_o,
  output logic [cu_cache_pkg::DATA_W-1:0]   mem_wdata_o,
  output logic [cu_cache_pkg::STRB_W-1:0]   mem_wstrb_o,
  input  logic                              mem_ready_i,
  input  logic [cu_cache_pkg::DATA_W-1:0]   mem_rdata_i,
  input  logic                              mem_rvalid_i,
  // engine responses
  output logic                              resp_valid_o,
  input  logic                              resp_ready_i,
  output cu_cache_pkg::cmd_e                resp_cmd_o,
  output logic [cu_cache_pkg::TAG_W-1:0]    resp_tag_o,
  output logic [cu_cache_pkg::DATA_W-1:0]   resp_data_o,
  output logic                              done_o
);

  // ingress to sequencer
  logic                            head_valid;
  cu_cache_pkg::cmd_e              head_cmd;
  logic [cu_cache_pkg::ADDR_W-1:0] head_addr;
  logic [cu_cache_pkg::DATA_W-1:0] head_wdata;
  logic [cu_cache_pkg::TAG_W-1:0]  head_tag;
  logic                            req_empty;
  logic                            req_pop;

  // sequencer to egress
  logic                            resp_push;
  cu_cache_pkg::cmd_e              push_cmd;
  logic [cu_cache_pkg::TAG_W-1:0]  push_tag;
  logic [cu_cache_pkg::DATA_W-1:0] push_data;
  logic                            resp_full;
  logic                            seq_idle;

  // ------------------------------
  // input side
  // ------------------------------
  cu_request_ingress u_ingress (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .desc_valid_i   (desc_valid_i),
    .desc_base_i    (desc_base_i),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .req_cmd_i      (req_cmd_i),
    .req_addr_i     (req_addr_i),
    .req_wdata_i    (req_wdata_i),
    .req_tag_i      (req_tag_i),
    .pop_i          (req_pop),
    .head_valid_o   (head_valid),
    .head_cmd_o     (head_cmd),
    .head_addr_o    (head_addr),
    .head_wdata_o   (head_wdata),
    .head_tag_o     (head_tag),
    .req_empty_o    (req_empty)
  );

  // ------------------------------
  // command sequencer
  // ------------------------------
  cu_command_sequencer u_sequencer (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .head_valid_i   (head_valid),
    .head_cmd_i     (head_cmd),
    .head_addr_i    (head_addr),
    .head_wdata_i   (head_wdata),
    .head_tag_i     (head_tag),
    .pop_o          (req_pop),
    .mem_valid_o    (mem_valid_o),
    .mem_addr_o     (mem_addr_o),
    .mem_wdata_o    (mem_wdata_o),
    .mem_wstrb_o    (mem_wstrb_o),
    .mem_ready_i    (mem_ready_i),
    .mem_rdata_i    (mem_rdata_i),
    .mem_rvalid_i   (mem_rvalid_i),
    .push_o         (resp_push),
    .push_cmd_o     (push_cmd),
    .push_tag_o     (push_tag),
    .push_data_o    (push_data),
    .resp_full_i    (resp_full),
    .seq_idle_o     (seq_idle)
  );

  // ------------------------------
  // output side
  // ------------------------------
  cu_response_egress u_egress (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .push_i         (resp_push),
    .push_cmd_i     (push_cmd),
    .push_tag_i     (push_tag),
    .push_data_i    (push_data),
    .resp_full_o    (resp_full),
    .resp_valid_o   (resp_valid_o),
    .resp_ready_i   (resp_ready_i),
    .resp_cmd_o     (resp_cmd_o),
    .resp_tag_o     (resp_tag_o),
    .resp_data_o    (resp_data_o),
    .req_empty_i    (req_empty),
    .seq_idle_i     (seq_idle),
    .mem_ready_i    (mem_ready_i),
    .done_o         (done_o)
  );

endmodule

//--- logic/cu_response_egress.sv
// output side: response FIFO, engine pop handshake and the registered done flag
`timescale 1ns/1ps

module cu_response_egress (
  input  logic                              ap_clk,
  input  logic                              areset_control,
  input  logic                              push_i,
  input  cu_cache_pkg::cmd_e                push_cmd_i,
  input  logic [cu_cache_pkg::TAG_W-1:0]    push_tag_i,
  input  logic [cu_cache_pkg::DATA_W-1:0]   push_data_i,
  output logic                              resp_full_o,
  output logic                              resp_valid_o,
  input  logic                              resp_ready_i,
  output cu_cache_pkg::cmd_e                resp_cmd_o,
  output logic [cu_cache_pkg::TAG_W-1:0]    resp_tag_o,
  output logic [cu_cache_pkg::DATA_W-1:0]   resp_data_o,
  input  logic                              req_empty_i,
  input  logic                              seq_idle_i,
  input  logic                              mem_ready_i,
  output logic                              done_o
);

  logic [cu_cache_pkg::RESP_ENTRY_W-1:0] fifo_dout;
  logic                                  fifo_empty;
  logic                                  resp_cmd_bit;
  logic                                  done_pre_q;

  // ------------------------------
  // response FIFO
  // ------------------------------
  cu_sync_fifo #(
    .DEPTH  (cu_cache_pkg::RESP_FIFO_DEPTH),
    .WIDTH  (cu_cache_pkg::RESP_ENTRY_W),
    .THRESH (cu_cache_pkg::PROG_THRESH)
  ) u_resp_fifo (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .wr_en_i        (push_i),
    .din_i          ({push_cmd_i, push_tag_i, push_data_i}),
    .rd_en_i        (resp_valid_o & resp_ready_i),
    .dout_o         (fifo_dout),
    .empty_o        (fifo_empty),
    .full_o         (),
    .prog_full_o    (resp_full_o)
  );

  // FWFT head stays put until popped
  assign resp_valid_o = ~fifo_empty;
  assign {resp_cmd_bit, resp_tag_o, resp_data_o} = fifo_dout;
  assign resp_cmd_o = cu_cache_pkg::cmd_e'(resp_cmd_bit);

  // ------------------------------
  // done detection, two flops deep
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      done_pre_q <= 1'b0;
      done_o     <= 1'b0;
    end else begin
      done_pre_q <= req_empty_i & seq_idle_i & fifo_empty & mem_ready_i;
      done_o     <= done_pre_q;
    end
  end

endmodule

//--- logic/cu_command_sequencer.sv
// command FSM: issues one buffered request at a time to memory and queues its completion
`timescale 1ns/1ps

module cu_command_sequencer (
  input  logic                              ap_clk,
  input  logic                              areset_control,
  input  logic                              head_valid_i,
  input  cu_cache_pkg::cmd_e                head_cmd_i,
  input  logic [cu_cache_pkg::ADDR_W-1:0]   head_addr_i,
  input  logic [cu_cache_pkg::DATA_W-1:0]   head_wdata_i,
  input  logic [cu_cache_pkg::TAG_W-1:0]    head_tag_i,
  output logic                              pop_o,
  output logic                              mem_valid_o,
  output logic [cu_cache_pkg::ADDR_W-1:0]   mem_addr_o,
  output logic [cu_cache_pkg::DATA_W-1:0]   mem_wdata_o,
  output logic [cu_cache_pkg::STRB_W-1:0]   mem_wstrb_o,
  input  logic                              mem_ready_i,
  input  logic [cu_cache_pkg::DATA_W-1:0]   mem_rdata_i,
  input  logic                              mem_rvalid_i,
  output logic                              push_o,
  output cu_cache_pkg::cmd_e                push_cmd_o,
  output logic [cu_cache_pkg::TAG_W-1:0]    push_tag_o,
  output logic [cu_cache_pkg::DATA_W-1:0]   push_data_o,
  input  logic                              resp_full_i,
  output logic                              seq_idle_o
);

  cu_cache_pkg::seq_state_e state_q;
  cu_cache_pkg::seq_state_e state_d;

  // command currently in flight
  cu_cache_pkg::cmd_e             cmd_q;
  logic [cu_cache_pkg::TAG_W-1:0] tag_q;

  logic start_cmd;
  logic is_write;
  logic read_done;

  // head valid, memory ready and room in the response queue
  assign start_cmd = (state_q == cu_cache_pkg::SEQ_READY) & head_valid_i & mem_ready_i
                     & ~resp_full_i;
  assign is_write  = (head_cmd_i == cu_cache_pkg::CMD_WRITE);
  // first rvalid after the issue cycle
  assign read_done = (state_q == cu_cache_pkg::SEQ_WAIT) & (cmd_q == cu_cache_pkg::CMD_READ)
                     & mem_rvalid_i;

  // ------------------------------
  // state register
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state_q <= cu_cache_pkg::SEQ_RESET;
    end else begin
      state_q <= state_d;
    end
  end

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      cu_cache_pkg::SEQ_RESET: begin
        state_d = cu_cache_pkg::SEQ_READY;
      end
      cu_cache_pkg::SEQ_READY: begin
        if (start_cmd) begin
          state_d = cu_cache_pkg::SEQ_ISSUE;
        end
      end
      cu_cache_pkg::SEQ_ISSUE: begin
        state_d = cu_cache_pkg::SEQ_WAIT;
      end
      cu_cache_pkg::SEQ_WAIT: begin
        // writes finish after one cycle here
        if (cmd_q == cu_cache_pkg::CMD_WRITE || read_done) begin
          state_d = cu_cache_pkg::SEQ_POP;
        end
      end
      cu_cache_pkg::SEQ_POP: begin
        state_d = cu_cache_pkg::SEQ_READY;
      end
      default: begin
        state_d = cu_cache_pkg::SEQ_RESET;
      end
    endcase
  end

  // ------------------------------
  // memory request
  // ------------------------------
  // single-cycle pulse, the cycle after ready was seen
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      mem_valid_o <= 1'b0;
    end else begin
      mem_valid_o <= start_cmd;
    end
  end

  // fields latched at the decision, held until the next command
  always_ff @(posedge ap_clk) begin
    if (start_cmd) begin
      mem_addr_o  <= head_addr_i;
      mem_wdata_o <= head_wdata_i;
      mem_wstrb_o <= is_write ? '1 : '0;
      cmd_q       <= head_cmd_i;
      tag_q       <= head_tag_i;
      // write completions echo the write data
      push_data_o <= head_wdata_i;
    end else if (read_done) begin
      push_data_o <= mem_rdata_i;
    end
  end

  // ------------------------------
  // completion
  // ------------------------------
  // push the response and retire the request together
  assign push_o     = (state_q == cu_cache_pkg::SEQ_POP);
  assign pop_o      = (state_q == cu_cache_pkg::SEQ_POP);
  assign push_cmd_o = cmd_q;
  assign push_tag_o = tag_q;

  assign seq_idle_o = (state_q == cu_cache_pkg::SEQ_READY);

endmodule

//--- logic/cu_request_ingress.sv
// input side: descriptor capture, request register stage, request FIFO and mapped head
`timescale 1ns/1ps

module cu_request_ingress (
  input  logic                              ap_clk,
  input  logic                              areset_control,
  input  logic                              desc_valid_i,
  input  logic [cu_cache_pkg::ADDR_W-1:0]   desc_base_i,
  input  logic                              req_valid_i,
  output logic                              req_ready_o,
  input  cu_cache_pkg::cmd_e                req_cmd_i,
  input  logic [cu_cache_pkg::ADDR_W-1:0]   req_addr_i,
  input  logic [cu_cache_pkg::DATA_W-1:0]   req_wdata_i,
  input  logic [cu_cache_pkg::TAG_W-1:0]    req_tag_i,
  input  logic                              pop_i,
  output logic                              head_valid_o,
  output cu_cache_pkg::cmd_e                head_cmd_o,
  output logic [cu_cache_pkg::ADDR_W-1:0]   head_addr_o,
  output logic [cu_cache_pkg::DATA_W-1:0]   head_wdata_o,
  output logic [cu_cache_pkg::TAG_W-1:0]    head_tag_o,
  output logic                              req_empty_o
);

  // captured kernel descriptor
  logic                            desc_valid_q;
  logic [cu_cache_pkg::ADDR_W-1:0] desc_base_q;

  // request register stage
  logic                            stage_valid_q;
  cu_cache_pkg::cmd_e              stage_cmd_q;
  logic [cu_cache_pkg::ADDR_W-1:0] stage_addr_q;
  logic [cu_cache_pkg::DATA_W-1:0] stage_wdata_q;
  logic [cu_cache_pkg::TAG_W-1:0]  stage_tag_q;

  // FIFO side
  logic [cu_cache_pkg::REQ_ENTRY_W-1:0] fifo_dout;
  logic                                 fifo_prog_full;
  logic                                 fifo_cmd_bit;
  logic [cu_cache_pkg::ADDR_W-1:0]      fifo_addr;

  // ------------------------------
  // descriptor and handshake
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      desc_valid_q  <= 1'b0;
      req_ready_o   <= 1'b0;
      stage_valid_q <= 1'b0;
    end else begin
      // sticky until reset
      if (desc_valid_i) begin
        desc_valid_q <= 1'b1;
      end
      // registered ready from the threshold, headroom covers the stage
      req_ready_o   <= ~fifo_prog_full;
      stage_valid_q <= req_valid_i & req_ready_o;
    end
  end

  // payload registers
  always_ff @(posedge ap_clk) begin
    if (desc_valid_i) begin
      desc_base_q <= desc_base_i;
    end
    stage_cmd_q   <= req_cmd_i;
    stage_addr_q  <= req_addr_i;
    stage_wdata_q <= req_wdata_i;
    stage_tag_q   <= req_tag_i;
  end

  // ------------------------------
  // request FIFO
  // ------------------------------
  cu_sync_fifo #(
    .DEPTH  (cu_cache_pkg::REQ_FIFO_DEPTH),
    .WIDTH  (cu_cache_pkg::REQ_ENTRY_W),
    .THRESH (cu_cache_pkg::PROG_THRESH)
  ) u_req_fifo (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .wr_en_i        (stage_valid_q),
    .din_i          ({stage_cmd_q, stage_addr_q, stage_wdata_q, stage_tag_q}),
    .rd_en_i        (pop_i),
    .dout_o         (fifo_dout),
    .empty_o        (req_empty_o),
    .full_o         (),
    .prog_full_o    (fifo_prog_full)
  );

  assign {fifo_cmd_bit, fifo_addr, head_wdata_o, head_tag_o} = fifo_dout;
  assign head_cmd_o = cu_cache_pkg::cmd_e'(fifo_cmd_bit);

  // base added at the head, so requests queued before the descriptor map too
  assign head_addr_o = fifo_addr + desc_base_q;

  // no work leaves before a descriptor
  assign head_valid_o = ~req_empty_o & desc_valid_q;

endmodule

//--- logic/cu_sync_fifo.sv
// synchronous first-word-fall-through FIFO instantiated for the request and response queues
`timescale 1ns/1ps

module cu_sync_fifo #(
  parameter int DEPTH  = 16,
  parameter int WIDTH  = 32,
  parameter int THRESH = 12
) (
  input  logic             ap_clk,
  input  logic             areset_control,
  input  logic             wr_en_i,
  input  logic [WIDTH-1:0] din_i,
  input  logic             rd_en_i,
  output logic [WIDTH-1:0] dout_o,
  output logic             empty_o,
  output logic             full_o,
  output logic             prog_full_o
);

  // entry storage
  logic [WIDTH-1:0] mem [DEPTH];

  // pointers wrap at DEPTH which is a power of two
  logic [$clog2(DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(DEPTH)-1:0]   rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0] count_q;

  logic wr_ok;
  logic rd_ok;

  // ------------------------------
  // flags
  // ------------------------------
  assign empty_o     = (count_q == '0);
  assign full_o      = (int'(count_q) == DEPTH);
  assign prog_full_o = (int'(count_q) >= THRESH);

  // overflow and underflow attempts dropped
  assign wr_ok = wr_en_i & ~full_o;
  assign rd_ok = rd_en_i & ~empty_o;

  // head visible without a read strobe
  assign dout_o = mem[rd_ptr_q];

  // ------------------------------
  // pointers and fill count
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop keeps the count
      case ({wr_ok, rd_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // write port
  always_ff @(posedge ap_clk) begin
    if (wr_ok) begin
      mem[wr_ptr_q] <= din_i;
    end
  end

endmodule

//--- logic/cu_cache_pkg.sv
// shared widths, queue depths and encodings of the cache front-end, used by scoped name
package cu_cache_pkg;

  // ------------------------------
  // bus widths
  // ------------------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  // one strobe bit per data byte
  localparam int STRB_W = DATA_W / 8;
  localparam int TAG_W  = 8;

  // ------------------------------
  // queue sizing
  // ------------------------------
  localparam int REQ_FIFO_DEPTH  = 16;
  localparam int RESP_FIFO_DEPTH = 16;
  // leaves four slots for requests still in flight behind the registered ready
  localparam int PROG_THRESH     = 12;

  // request entry is {cmd, addr, wdata, tag}
  localparam int REQ_ENTRY_W  = 1 + ADDR_W + DATA_W + TAG_W;
  // response entry is {cmd, tag, data}
  localparam int RESP_ENTRY_W = 1 + TAG_W + DATA_W;

  // ------------------------------
  // encodings
  // ------------------------------
  // command opcode carried with every request and response
  typedef enum logic {
    CMD_READ  = 1'b0,
    CMD_WRITE = 1'b1
  } cmd_e;

  // command sequencer states
  typedef enum logic [2:0] {
    SEQ_RESET = 3'd0,
    SEQ_READY = 3'd1,
    SEQ_ISSUE = 3'd2,
    SEQ_WAIT  = 3'd3,
    SEQ_POP   = 3'd4
  } seq_state_e;

endpackage
